// File: logic/ov_pkg.sv
// fixed 80x60 rgb444 image and 640x480 vga timing in pixel periods; sizes change only here
package ov_pkg;

  // image kept in both frame buffers, qqvga halved
  localparam int IMG_COLS = 80;
  localparam int IMG_ROWS = 60;
  localparam int IMG_PXLS = IMG_COLS * IMG_ROWS; // 4800 words
  localparam int ADDR_W   = 13;                  // 2^13 covers 4800
  localparam int PXL_W    = 12;                  // r 11..8, g 7..4, b 3..0

  // horizontal timing, in pixel periods
  localparam int H_VISIBLE = 640;
  localparam int H_FRONT   = 16;
  localparam int H_SYNC    = 96;
  localparam int H_BACK    = 48;
  localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK; // 800

  // vertical timing, in lines
  localparam int V_VISIBLE = 480;
  localparam int V_FRONT   = 10;
  localparam int V_SYNC    = 2;
  localparam int V_BACK    = 33;
  localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK; // 525

  localparam int COL_W = 10; // col and row counters, up to 1023

  // colour filter, stepped by proc_ctrl in this order
  typedef enum logic [1:0] {FILT_NONE, FILT_RED, FILT_GREEN, FILT_BLUE} filter_t;

  // which byte of the rgb444 pair comes next
  typedef enum logic {CAP_HIGH, CAP_LOW} cap_state_t;

endpackage

// File: logic/ov7670_capture.sv
// camera pins are sampled with clk, so pclk must be under a quarter of clk; rgb444 only
`timescale 1ns/1ps

module ov7670_capture (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        pclk,
  input  logic                        vsync,
  input  logic                        href,
  input  logic [7:0]                  d,
  output logic                        we,
  output logic [ov_pkg::ADDR_W-1:0]   addr,
  output logic [ov_pkg::PXL_W-1:0]    dout
);

  logic [1:0]                pclk_s;  // two flop sync, [1] is safe to use
  logic                      pclk_q;  // previous synced pclk for edge detect
  logic [1:0]                vsync_s;
  logic [1:0]                href_s;
  logic [7:0]                d_s1;    // data follows the strobes through two stages
  logic [7:0]                d_s2;
  logic                      pclk_rise;
  ov_pkg::cap_state_t        byte_ph; // byte phase inside a pixel
  logic [3:0]                red_q;   // red nibble waiting for its green/blue byte
  logic [ov_pkg::ADDR_W-1:0] wr_addr; // next pixel position in the frame

  assign pclk_rise = pclk_s[1] & ~pclk_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pclk_s  <= '0;
      pclk_q  <= 1'b0;
      vsync_s <= '0;
      href_s  <= '0;
    end else begin
      pclk_s  <= {pclk_s[0], pclk};
      pclk_q  <= pclk_s[1];
      vsync_s <= {vsync_s[0], vsync};
      href_s  <= {href_s[0], href};
    end
  end

  always_ff @(posedge clk) begin
    d_s1 <= d;
    d_s2 <= d_s1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      we      <= 1'b0;
      byte_ph <= ov_pkg::CAP_HIGH;
      wr_addr <= '0;
    end else begin
      we <= 1'b0; // single cycle strobe
      if (vsync_s[1]) begin // frame start, rewind
        byte_ph <= ov_pkg::CAP_HIGH;
        wr_addr <= '0;
      end else if (pclk_rise && href_s[1]) begin
        if (byte_ph == ov_pkg::CAP_HIGH) begin
          red_q   <= d_s2[3:0]; // first byte xxxxrrrr
          byte_ph <= ov_pkg::CAP_LOW;
        end else begin
          dout    <= {red_q, d_s2}; // second byte ggggbbbb
          addr    <= wr_addr;
          we      <= (wr_addr < ov_pkg::IMG_PXLS); // drop anything past the frame
          byte_ph <= ov_pkg::CAP_HIGH;
          if (wr_addr < ov_pkg::IMG_PXLS)
            wr_addr <= wr_addr + 1'b1; // saturates at IMG_PXLS
        end
      end
    end
  end

  a_we_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    we |-> (addr < ov_pkg::IMG_PXLS));

endmodule

// File: logic/frame_buffer.sv
// simple dual port ram, read data one clk after addrb, a same-address read returns old data
`timescale 1ns/1ps

module frame_buffer (
  input  logic                      clk,
  input  logic                      wea,
  input  logic [ov_pkg::ADDR_W-1:0] addra,
  input  logic [ov_pkg::PXL_W-1:0]  dina,
  input  logic [ov_pkg::ADDR_W-1:0] addrb,
  output logic [ov_pkg::PXL_W-1:0]  doutb
);

  logic [ov_pkg::PXL_W-1:0] mem [ov_pkg::IMG_PXLS]; // one word per pixel, maps to block ram

  // write port
  always_ff @(posedge clk) begin
    if (wea)
      mem[addra] <= dina;
  end

  always_ff @(posedge clk) begin
    doutb <= mem[addrb]; // registered read port
  end

  // writers must keep inside the 4800 words
  a_addra_range: assert property (@(posedge clk)
    wea |-> (addra < ov_pkg::IMG_PXLS));

endmodule

// File: logic/color_proc.sv
// sweeps the camera buffer nonstop, one pixel per clk; red count is per whole sweep, unfiltered
`timescale 1ns/1ps

module color_proc (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      proc_ctrl,
  input  logic [ov_pkg::PXL_W-1:0]  orig_pxl,
  output logic [ov_pkg::ADDR_W-1:0] orig_addr,
  output logic                      proc_we,
  output logic [ov_pkg::ADDR_W-1:0] proc_addr,
  output logic [ov_pkg::PXL_W-1:0]  proc_pxl,
  output ov_pkg::filter_t           filter_mode,
  output logic [ov_pkg::ADDR_W-1:0] red_pixels
);

  logic                      ctrl_s;    // synced button level
  logic                      ctrl_q;
  logic                      rd_v;      // stage 1, read data arrives this cycle
  logic [ov_pkg::ADDR_W-1:0] rd_a;      // address of that read
  ov_pkg::filter_t           rd_f;      // filter sampled when the read was issued
  logic [ov_pkg::PXL_W-1:0]  filt_pxl;
  logic                      is_red;
  logic                      sweep_end; // last write of the sweep is on the bus
  logic [ov_pkg::ADDR_W-1:0] red_cnt;   // running count of this sweep

  // keep one field, zero the rest
  always_comb begin
    case (rd_f)
      ov_pkg::FILT_RED:   filt_pxl = {orig_pxl[11:8], 8'h00};
      ov_pkg::FILT_GREEN: filt_pxl = {4'h0, orig_pxl[7:4], 4'h0};
      ov_pkg::FILT_BLUE:  filt_pxl = {8'h00, orig_pxl[3:0]};
      default:            filt_pxl = orig_pxl; // none, pass through
    endcase
  end

  assign is_red = rd_v && (orig_pxl[11:8] > orig_pxl[7:4]) && (orig_pxl[11:8] > orig_pxl[3:0]);
  assign sweep_end = proc_we && (proc_addr == ov_pkg::IMG_PXLS - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl_s      <= 1'b0;
      ctrl_q      <= 1'b0;
      filter_mode <= ov_pkg::FILT_NONE;
    end else begin
      ctrl_s <= proc_ctrl;
      ctrl_q <= ctrl_s;
      if (ctrl_s && !ctrl_q) begin // rising edge steps the mode
        case (filter_mode)
          ov_pkg::FILT_NONE:  filter_mode <= ov_pkg::FILT_RED;
          ov_pkg::FILT_RED:   filter_mode <= ov_pkg::FILT_GREEN;
          ov_pkg::FILT_GREEN: filter_mode <= ov_pkg::FILT_BLUE;
          default:            filter_mode <= ov_pkg::FILT_NONE;
        endcase
      end
    end
  end

  // read address, stage 1 and stage 2 control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      orig_addr  <= '0;
      rd_v       <= 1'b0;
      proc_we    <= 1'b0;
      red_cnt    <= '0;
      red_pixels <= '0;
    end else begin
      orig_addr <= (orig_addr == ov_pkg::IMG_PXLS - 1) ? '0 : orig_addr + 1'b1;
      rd_v      <= 1'b1; // every cycle issues a read
      proc_we   <= rd_v;
      if (sweep_end) begin
        red_pixels <= red_cnt;
        red_cnt    <= ov_pkg::ADDR_W'(is_red); // pixel 0 of the next sweep
      end else begin
        red_cnt <= red_cnt + ov_pkg::ADDR_W'(is_red);
      end
    end
  end

  // payload follows the valid bits
  always_ff @(posedge clk) begin
    rd_a      <= orig_addr;
    rd_f      <= filter_mode;
    proc_addr <= rd_a;
    proc_pxl  <= filt_pxl;
  end

  a_proc_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    proc_we |-> (proc_addr < ov_pkg::IMG_PXLS));

endmodule

// File: logic/vga_sync.sv
// 640x480 at half the clk rate, clk must be 50 MHz for standard 60 Hz; syncs active low
`timescale 1ns/1ps

module vga_sync (
  input  logic                     clk,
  input  logic                     rst_n,
  output logic                     new_pxl,
  output logic                     visible,
  output logic                     hsync,
  output logic                     vsync,
  output logic [ov_pkg::COL_W-1:0] col,
  output logic [ov_pkg::COL_W-1:0] row
);

  // divide by two, first pixel strobe right after reset
  always_ff @(posedge clk) begin
    if (!rst_n)
      new_pxl <= 1'b0;
    else
      new_pxl <= ~new_pxl;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col <= '0;
      row <= '0;
    end else if (new_pxl) begin
      if (col == ov_pkg::H_TOTAL - 1) begin // end of line
        col <= '0;
        if (row == ov_pkg::V_TOTAL - 1)
          row <= '0; // end of frame
        else
          row <= row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  assign visible = (col < ov_pkg::H_VISIBLE) && (row < ov_pkg::V_VISIBLE);

  // sync pulse sits after the front porch
  assign hsync = !((col >= ov_pkg::H_VISIBLE + ov_pkg::H_FRONT) &&
                   (col <  ov_pkg::H_VISIBLE + ov_pkg::H_FRONT + ov_pkg::H_SYNC));
  assign vsync = !((row >= ov_pkg::V_VISIBLE + ov_pkg::V_FRONT) &&
                   (row <  ov_pkg::V_VISIBLE + ov_pkg::V_FRONT + ov_pkg::V_SYNC));

  a_col_range: assert property (@(posedge clk) disable iff (!rst_n)
    col < ov_pkg::H_TOTAL);

endmodule

// File: logic/vga_display.sv
// shows the 80x60 buffer 1:1 in the top-left corner, rest black; outputs lag new_pxl by 2 clk
`timescale 1ns/1ps

module vga_display (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      new_pxl,
  input  logic                      visible,
  input  logic                      hsync_in,
  input  logic                      vsync_in,
  input  logic [ov_pkg::COL_W-1:0]  col,
  input  logic [ov_pkg::COL_W-1:0]  row,
  input  logic [ov_pkg::PXL_W-1:0]  frame_pixel,
  output logic [ov_pkg::ADDR_W-1:0] frame_addr,
  output logic [3:0]                vga_red,
  output logic [3:0]                vga_green,
  output logic [3:0]                vga_blue,
  output logic                      vga_hsync,
  output logic                      vga_vsync
);

  logic in_win; // current pixel lies in the image corner
  logic pxl_d;  // buffer data for the last new_pxl is ready
  logic win_d;
  logic hs_d;
  logic vs_d;

  assign in_win = visible && (col < ov_pkg::IMG_COLS) && (row < ov_pkg::IMG_ROWS);
  assign frame_addr = in_win ? ov_pkg::ADDR_W'(row * ov_pkg::IMG_COLS + col) : '0;

  // stage 1, lines up with the buffer read latency
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pxl_d <= 1'b0;
      win_d <= 1'b0;
      hs_d  <= 1'b1;
      vs_d  <= 1'b1;
    end else begin
      pxl_d <= new_pxl;
      if (new_pxl) begin
        win_d <= in_win;
        hs_d  <= hsync_in;
        vs_d  <= vsync_in;
      end
    end
  end

  // stage 2, colours and syncs leave together
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vga_red   <= 4'h0;
      vga_green <= 4'h0;
      vga_blue  <= 4'h0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
    end else if (pxl_d) begin
      vga_red   <= win_d ? frame_pixel[11:8] : 4'h0; // black outside the image
      vga_green <= win_d ? frame_pixel[7:4]  : 4'h0;
      vga_blue  <= win_d ? frame_pixel[3:0]  : 4'h0;
      vga_hsync <= hs_d;
      vga_vsync <= vs_d;
    end
  end

endmodule

// File: logic/ov_vision_top.sv
// single clock domain, camera assumed configured for rgb444 elsewhere; 4 bit colour outputs
`timescale 1ns/1ps

module ov_vision_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ov7670_pclk,
  input  logic                      ov7670_vsync,
  input  logic                      ov7670_href,
  input  logic [7:0]                ov7670_d,
  input  logic                      proc_ctrl,
  output logic [3:0]                vga_red,
  output logic [3:0]                vga_green,
  output logic [3:0]                vga_blue,
  output logic                      vga_hsync,
  output logic                      vga_vsync,
  output ov_pkg::filter_t           filter_mode,
  output logic [ov_pkg::ADDR_W-1:0] red_pixels
);

  logic                      cap_we;    // camera side of cam_fb
  logic [ov_pkg::ADDR_W-1:0] cap_addr;
  logic [ov_pkg::PXL_W-1:0]  cap_pxl;
  logic [ov_pkg::ADDR_W-1:0] orig_addr; // processor reads cam_fb
  logic [ov_pkg::PXL_W-1:0]  orig_pxl;
  logic                      proc_we;   // processor writes proc_fb
  logic [ov_pkg::ADDR_W-1:0] proc_addr;
  logic [ov_pkg::PXL_W-1:0]  proc_pxl;
  logic [ov_pkg::ADDR_W-1:0] disp_addr; // display reads proc_fb
  logic [ov_pkg::PXL_W-1:0]  disp_pxl;
  logic                      new_pxl;
  logic                      visible;
  logic                      hsync;
  logic                      vsync;
  logic [ov_pkg::COL_W-1:0]  col;
  logic [ov_pkg::COL_W-1:0]  row;

  ov7670_capture capture (.clk(clk), .rst_n(rst_n), .pclk(ov7670_pclk), .vsync(ov7670_vsync),
    .href(ov7670_href), .d(ov7670_d), .we(cap_we), .addr(cap_addr), .dout(cap_pxl));

  frame_buffer cam_fb (.clk(clk), .wea(cap_we), .addra(cap_addr), .dina(cap_pxl),
    .addrb(orig_addr), .doutb(orig_pxl));

  color_proc img_proc (.clk(clk), .rst_n(rst_n), .proc_ctrl(proc_ctrl), .orig_pxl(orig_pxl),
    .orig_addr(orig_addr), .proc_we(proc_we), .proc_addr(proc_addr), .proc_pxl(proc_pxl),
    .filter_mode(filter_mode), .red_pixels(red_pixels));

  frame_buffer proc_fb (.clk(clk), .wea(proc_we), .addra(proc_addr), .dina(proc_pxl),
    .addrb(disp_addr), .doutb(disp_pxl));

  vga_sync sync_gen (.clk(clk), .rst_n(rst_n), .new_pxl(new_pxl), .visible(visible),
    .hsync(hsync), .vsync(vsync), .col(col), .row(row));

  vga_display display (.clk(clk), .rst_n(rst_n), .new_pxl(new_pxl), .visible(visible),
    .hsync_in(hsync), .vsync_in(vsync), .col(col), .row(row), .frame_pixel(disp_pxl),
    .frame_addr(disp_addr), .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync));

endmodule

// File: bench/tb_ov_vision.sv
// one random camera frame, then checks over ~6 vga frames (about 5M clk); screen lock on vsync
`timescale 1ns/1ps

module tb_ov_vision;

  localparam int WIN_TIMEOUT  = 2_000_000; // in clk cycles where one vga frame is 840000
  localparam int CTRL_TIMEOUT = 32;
  localparam int HS_START     = ov_pkg::H_VISIBLE + ov_pkg::H_FRONT;
  localparam int VS_START     = ov_pkg::V_VISIBLE + ov_pkg::V_FRONT;

  logic                      clk;
  logic                      rst_n;
  logic                      ov7670_pclk;
  logic                      ov7670_vsync;
  logic                      ov7670_href;
  logic [7:0]                ov7670_d;
  logic                      proc_ctrl;
  logic [3:0]                vga_red;
  logic [3:0]                vga_green;
  logic [3:0]                vga_blue;
  logic                      vga_hsync;
  logic                      vga_vsync;
  ov_pkg::filter_t           filter_mode;
  logic [ov_pkg::ADDR_W-1:0] red_pixels;

  logic [ov_pkg::PXL_W-1:0]  img [ov_pkg::IMG_PXLS]; // what the camera model sends
  logic [ov_pkg::ADDR_W-1:0] exp_red;
  bit                        want_check; // set by main and taken at screen pixel 0,0
  ov_pkg::filter_t           want_filt;
  bit                        act_check;
  ov_pkg::filter_t           act_filt;
  bit                        tracking;   // screen position known
  bit                        prev_vs;
  bit                        phase;      // outputs move every second clk
  int                        scr_row;
  int                        scr_col;
  int                        done_cnt;   // image windows checked end to end

  ov_vision_top ov_vision_top_inst (.clk(clk), .rst_n(rst_n), .ov7670_pclk(ov7670_pclk),
    .ov7670_vsync(ov7670_vsync), .ov7670_href(ov7670_href), .ov7670_d(ov7670_d),
    .proc_ctrl(proc_ctrl), .vga_red(vga_red), .vga_green(vga_green), .vga_blue(vga_blue),
    .vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .filter_mode(filter_mode),
    .red_pixels(red_pixels));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns
  end

  // field masks follow r 11..8, g 7..4, b 3..0
  function automatic logic [11:0] apply_filter(input logic [11:0] p, input ov_pkg::filter_t f);
    case (f)
      ov_pkg::FILT_RED:   return p & 12'hf00;
      ov_pkg::FILT_GREEN: return p & 12'h0f0;
      ov_pkg::FILT_BLUE:  return p & 12'h00f;
      default:            return p;
    endcase
  endfunction

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_value(input string what, input logic [15:0] got, input logic [15:0] exp);
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", what, got, exp);
    abort_run();
  endtask

  // one camera byte with pclk low 2 clk then high 2 clk
  task automatic pclk_byte(input logic [7:0] b);
    ov7670_d    = b;
    ov7670_pclk = 1'b0;
    repeat (2) @(negedge clk);
    ov7670_pclk = 1'b1; // capture samples on this rise
    repeat (2) @(negedge clk);
  endtask

  task automatic send_frame();
    int idx;
    @(negedge clk);
    ov7670_vsync = 1'b1; // rewinds the write address
    repeat (8) @(negedge clk);
    ov7670_vsync = 1'b0;
    repeat (8) @(negedge clk);
    for (int r = 0; r < ov_pkg::IMG_ROWS; r++) begin
      ov7670_href = 1'b1;
      for (int c = 0; c < ov_pkg::IMG_COLS; c++) begin
        idx = r * ov_pkg::IMG_COLS + c;
        pclk_byte({4'($urandom), img[idx][11:8]}); // upper nibble is don't care
        pclk_byte(img[idx][7:0]);
      end
      ov7670_href = 1'b0;
      ov7670_pclk = 1'b0;
      repeat (8) @(negedge clk); // line gap
    end
  endtask

  task automatic check_pixel(input int r, input int c);
    logic [11:0] exp_pxl;
    logic        exp_hs;
    logic        exp_vs;
    bit          judge; // colours known at this position
    exp_hs  = !(c >= HS_START && c < HS_START + ov_pkg::H_SYNC);
    exp_vs  = !(r >= VS_START && r < VS_START + ov_pkg::V_SYNC);
    judge   = 1'b1;
    exp_pxl = 12'h000; // border and blanking stay black
    if (r < ov_pkg::IMG_ROWS && c < ov_pkg::IMG_COLS) begin
      judge   = act_check; // proc_fb holds the camera image only once main says so
      exp_pxl = apply_filter(img[r * ov_pkg::IMG_COLS + c], act_filt);
    end
    assert (vga_hsync == exp_hs)
      else report_value($sformatf("vga_hsync at row %0d col %0d", r, c), 16'(vga_hsync),
                        16'(exp_hs));
    assert (vga_vsync == exp_vs)
      else report_value($sformatf("vga_vsync at row %0d col %0d", r, c), 16'(vga_vsync),
                        16'(exp_vs));
    if (judge) begin
      assert (vga_red == exp_pxl[11:8])
        else report_value($sformatf("vga_red at row %0d col %0d", r, c), 16'(vga_red),
                          16'(exp_pxl[11:8]));
      assert (vga_green == exp_pxl[7:4])
        else report_value($sformatf("vga_green at row %0d col %0d", r, c), 16'(vga_green),
                          16'(exp_pxl[7:4]));
      assert (vga_blue == exp_pxl[3:0])
        else report_value($sformatf("vga_blue at row %0d col %0d", r, c), 16'(vga_blue),
                          16'(exp_pxl[3:0]));
    end
  endtask

  // screen tracker locks on the first vsync fall at line 490 col 0
  always @(negedge clk) begin
    if (!rst_n) begin
      tracking = 1'b0;
      prev_vs  = 1'b1;
      phase    = 1'b0;
    end else if (!tracking) begin
      if (prev_vs && !vga_vsync) begin
        tracking = 1'b1;
        scr_row  = VS_START;
        scr_col  = 0;
      end
      prev_vs = vga_vsync;
    end
    if (tracking) begin
      if (!phase) begin
        if (scr_row == 0 && scr_col == 0) begin
          act_check = want_check; // whole windows only
          act_filt  = want_filt;
        end
        check_pixel(scr_row, scr_col);
        if (act_check && scr_row == ov_pkg::IMG_ROWS - 1 && scr_col == ov_pkg::IMG_COLS - 1)
          done_cnt++;
        scr_col++;
        if (scr_col == ov_pkg::H_TOTAL) begin
          scr_col = 0;
          scr_row = (scr_row == ov_pkg::V_TOTAL - 1) ? 0 : scr_row + 1;
        end
      end
      phase = !phase;
    end
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic wait_windows();
    int start;
    int n;
    @(posedge clk);
    start = done_cnt;
    n = 0;
    while (done_cnt == start) begin
      @(posedge clk);
      n++;
      if (n > WIN_TIMEOUT) begin
        $display("timeout: no complete image window reached the vga outputs");
        abort_run();
      end
    end
  endtask

  task automatic check_red();
    @(negedge clk);
    assert (red_pixels == exp_red) else report_value("red_pixels", 16'(red_pixels), 16'(exp_red));
  endtask

  task automatic step_filter(input ov_pkg::filter_t exp_f);
    int n;
    @(negedge clk);
    proc_ctrl = 1'b1;
    n = 0;
    while (filter_mode != exp_f) begin
      @(negedge clk);
      n++;
      if (n > CTRL_TIMEOUT) begin
        $display("filter_mode did not step to %s after a proc_ctrl rise", exp_f.name());
        abort_run();
      end
    end
    proc_ctrl = 1'b0;
    repeat (4) @(negedge clk); // low level passes the synchronizer without a second step
    assert (filter_mode == exp_f)
      else report_value("filter_mode", 16'(filter_mode), 16'(exp_f));
  endtask

  initial begin
    int              reds;
    ov_pkg::filter_t next_f;
    rst_n        = 1'b0;
    ov7670_pclk  = 1'b0;
    ov7670_vsync = 1'b0;
    ov7670_href  = 1'b0;
    ov7670_d     = 8'h00;
    proc_ctrl    = 1'b0;
    void'($urandom(32'h0c3af4d0));
    reds         = 0;
    for (int i = 0; i < ov_pkg::IMG_PXLS; i++) begin
      img[i] = 12'($urandom);
      if (img[i][11:8] > img[i][7:4] && img[i][11:8] > img[i][3:0])
        reds++; // red beats both other fields
    end
    exp_red = ov_pkg::ADDR_W'(reds);
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    assert (vga_hsync && vga_vsync)
      else report_value("vga_hsync,vga_vsync after reset", 16'({vga_hsync, vga_vsync}), 16'h3);
    assert ({vga_red, vga_green, vga_blue} == 12'h000)
      else report_value("vga colours after reset", 16'({vga_red, vga_green, vga_blue}), 16'h0);
    assert (filter_mode == ov_pkg::FILT_NONE)
      else report_value("filter_mode after reset", 16'(filter_mode), 16'(ov_pkg::FILT_NONE));
    assert (red_pixels == '0) else report_value("red_pixels after reset", 16'(red_pixels), 16'h0);
    send_frame();
    wait_cycles(2 * ov_pkg::IMG_PXLS + 16); // last write lands and a whole sweep follows
    check_red();
    @(posedge clk);
    want_filt  = ov_pkg::FILT_NONE;
    want_check = 1'b1;
    wait_windows(); // pass-through frame
    next_f = ov_pkg::FILT_NONE;
    repeat (4) begin
      next_f = next_f.next(); // none, red, green, blue, none
      step_filter(next_f);
      @(posedge clk);
      want_filt = next_f;
      wait_cycles(ov_pkg::IMG_PXLS + 16); // proc_fb refilled before the next window
      check_red();
      wait_windows();
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: ov_vision.f
logic/ov_pkg.sv
logic/ov7670_capture.sv
logic/frame_buffer.sv
logic/color_proc.sv
logic/vga_sync.sv
logic/vga_display.sv
logic/ov_vision_top.sv
bench/tb_ov_vision.sv

// File: Makefile
# Verilator build of the camera to vga vision path
VERILATOR ?= verilator
TOP       ?= tb_ov_vision
FILELIST  ?= ov_vision.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard logic/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the pass/fail result
run: $(SIM)
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)
